// File: udp_frame_receiver.f
+incdir+sim
rtl/udp_rx_pkg.sv
rtl/crc32_engine.sv
rtl/frame_verdict.sv
rtl/frame_sequencer.sv
rtl/udp_frame_receiver.sv
sim/udp_frame_receiver_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module udp_frame_receiver_tb \
    -f udp_frame_receiver.f \
    -o udp_frame_receiver_sim \
    || { echo "Verilator build failed"; exit 1; }

output="$(./obj_dir/udp_frame_receiver_sim 2>&1)"
echo "$output"
echo "$output" | grep -qF '*** TEST PASSED ***' && exit 0 || exit 1

// File: sim/frame_driver.svh
logic [7:0] frame_bytes[$];
logic [7:0] payload_bytes[$];

//////////////////////////////////////////////////
// Frame building
//////////////////////////////////////////////////

function automatic void push_word(input logic [15:0] word);
    frame_bytes.push_back(word[15:8]);
    frame_bytes.push_back(word[7:0]);
endfunction

function automatic void push_random(input int count);
    repeat (count) begin
        frame_bytes.push_back(8'($urandom));
    end
endfunction

// Bitwise Ethernet CRC over everything built so far
function automatic logic [31:0] reference_crc();
    logic [31:0] crc;
    logic [7:0]  data;
    logic        feedback;
    crc = 32'hFFFF_FFFF;
    foreach (frame_bytes[i]) begin
        data = frame_bytes[i];
        for (int b = 0; b < 8; b++) begin
            feedback = crc[0] ^ data[0];
            data     = data >> 1;
            crc      = crc >> 1;
            if (feedback) begin
                crc = crc ^ CRC32_POLYNOMIAL;
            end
        end
    end
    return ~crc;
endfunction

function automatic void build_frame(
    input int          payload_length,
    input logic [15:0] ether_type,
    input logic [7:0]  protocol,
    input logic [15:0] flags
);
    logic [7:0]  value;
    logic [31:0] crc;
    int          pad_length;
    frame_bytes.delete();
    payload_bytes.delete();
    header_expect.ipv4_identification = 16'($urandom);
    header_expect.ipv4_flags          = flags;
    header_expect.udp_destination     = 16'($urandom);
    pad_length = (payload_length < MIN_PAYLOAD_BYTES) ? MIN_PAYLOAD_BYTES - payload_length : 0;

    // MAC addresses, then EtherType
    push_random(12);
    push_word(ether_type);
    frame_bytes.push_back(8'h45);
    frame_bytes.push_back(8'h00);
    push_word(16'(payload_length + HEADER_OVERHEAD_BYTES));
    push_word(header_expect.ipv4_identification);
    push_word(flags);
    frame_bytes.push_back(8'd64);
    frame_bytes.push_back(protocol);
    // Header checksum and both addresses
    push_random(10);
    push_random(2);
    push_word(header_expect.udp_destination);
    push_word(16'(payload_length + 8));
    push_random(2);
    repeat (payload_length) begin
        value = 8'($urandom);
        payload_bytes.push_back(value);
        frame_bytes.push_back(value);
    end
    repeat (pad_length) begin
        frame_bytes.push_back(8'h00);
    end
    crc = reference_crc();
    repeat (4) begin
        frame_bytes.push_back(crc[7:0]);
        crc = crc >> 8;
    end
endfunction

// Highest enabled slot as a one-hot vector
function automatic logic [RECEIVE_SLOTS-1:0] owner_slot(input logic [RECEIVE_SLOTS-1:0] enable);
    logic [RECEIVE_SLOTS-1:0] bit_mask;
    bit_mask = {1'b1, {(RECEIVE_SLOTS - 1){1'b0}}};
    while (bit_mask != '0 && (enable & bit_mask) == '0) begin
        bit_mask = bit_mask >> 1;
    end
    return bit_mask;
endfunction

//////////////////////////////////////////////////
// Byte driving
//////////////////////////////////////////////////

task automatic idle_cycles(input int count);
    data_enable = 1'b0;
    repeat (count) begin
        @(posedge clock);
        #1;
    end
endtask

// Held until data_ready is seen high ahead of an edge
task automatic drive_byte(input logic [7:0] value, input logic is_start, input logic is_last);
    logic accepted;
    frame_byte      = '{start: is_start, data: value};
    data_enable     = 1'b1;
    last_fcs_marker = is_last;
    accepted        = 1'b0;
    while (!accepted) begin
        @(negedge clock);
        accepted = data_ready;
        @(posedge clock);
        #1;
    end
    last_fcs_marker = 1'b0;
endtask

task automatic send_frame(input logic accepted, input logic fcs_ok, input int byte_limit);
    logic [RECEIVE_SLOTS-1:0] owner;
    int                       last;
    owner = accepted ? owner_slot(receive_slot_enable) : '0;
    last  = frame_bytes.size() - 1;
    if (!fcs_ok) begin
        frame_bytes[last - 1] ^= 8'h10;
    end
    good_expect = fcs_ok ? owner : '0;
    bad_expect  = fcs_ok ? '0 : owner;
    if (byte_limit > last && |owner) begin
        foreach (payload_bytes[i]) begin
            payload_expect[payload_write]      = payload_bytes[i];
            payload_slot_expect[payload_write] = owner;
            payload_write                      = payload_write + 10'd1;
        end
    end
    for (int i = 0; i <= last && i < byte_limit; i++) begin
        drive_byte(frame_bytes[i], i == 0, i == last);
        if (i < last && $urandom_range(3) == 0) begin
            idle_cycles(int'($urandom_range(2, 1)));
        end
    end
    data_enable = 1'b0;
endtask

// Start flag in mid-frame, reused as byte zero of the next frame
task automatic present_abort_start(input logic [7:0] value);
    abort_bad    = owner_slot(receive_slot_enable);
    frame_byte   = '{start: 1'b1, data: value};
    data_enable  = 1'b1;
    abort_marker = 1'b1;
    @(posedge clock);
    #1;
    abort_marker = 1'b0;
endtask

// File: sim/udp_frame_receiver_tb.sv
module udp_frame_receiver_tb
    import udp_rx_pkg::*;
();

    localparam int RECEIVE_SLOTS   = 2;
    localparam int FRAME_COUNT     = 12;
    localparam int MAX_FRAME_BYTES = 120;
    // Up to two idle cycles per byte, plus verdict and gaps
    localparam int TIMEOUT_CYCLES  = FRAME_COUNT * (MAX_FRAME_BYTES * 3 + 57);
    localparam int WHOLE_FRAME     = 4096;

    logic                     clock;
    logic                     reset_n;
    frame_byte_t              frame_byte;
    logic                     data_enable;
    logic [RECEIVE_SLOTS-1:0] receive_slot_enable;
    logic                     data_ready;
    logic [7:0]               packet_data;
    logic [RECEIVE_SLOTS-1:0] packet_data_valid;
    logic [RECEIVE_SLOTS-1:0] good_packet;
    logic [RECEIVE_SLOTS-1:0] bad_packet;
    header_fields_t           header_fields;

    // Scoreboard
    logic [7:0]               payload_expect [0:1023];
    logic [RECEIVE_SLOTS-1:0] payload_slot_expect [0:1023];
    logic [9:0]               payload_write;
    logic [9:0]               payload_read;
    logic [RECEIVE_SLOTS-1:0] good_expect;
    logic [RECEIVE_SLOTS-1:0] bad_expect;
    logic [RECEIVE_SLOTS-1:0] abort_bad;
    logic [RECEIVE_SLOTS-1:0] verdict_good;
    logic [RECEIVE_SLOTS-1:0] verdict_bad;
    header_fields_t           header_expect;
    header_fields_t           header_check;
    logic                     last_fcs_marker;
    logic                     abort_marker;
    logic                     drain_done;
    logic [1:0]               fcs_pipe;
    logic                     abort_pipe;
    int                       error_count   = 0;
    int                       errors_before = 0;
    int                       test_number   = 0;
    int                       verdict_count = 0;
    int                       cycle_count   = 0;

    udp_frame_receiver #(
        .RECEIVE_SLOTS(RECEIVE_SLOTS)
    ) dut (.*);

    `include "frame_driver.svh"

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Frame end and abort markers line up with the expected pulse cycle
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            payload_read <= '0;
            fcs_pipe     <= '0;
            abort_pipe   <= 1'b0;
            verdict_good <= '0;
            verdict_bad  <= '0;
            header_check <= '0;
        end else begin
            fcs_pipe   <= {fcs_pipe[0], data_enable && data_ready && last_fcs_marker};
            abort_pipe <= data_enable && abort_marker;
            if (data_enable && data_ready && last_fcs_marker) begin
                verdict_good <= good_expect;
                verdict_bad  <= bad_expect;
                header_check <= header_expect;
            end
            if (|packet_data_valid) begin
                payload_read <= payload_read + 10'd1;
            end
            if ((|good_packet) || (|bad_packet)) begin
                verdict_count <= verdict_count + 1;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    assert property (@(posedge clock) disable iff (!reset_n)
        |packet_data_valid |-> payload_read < payload_write)
    else begin
        $display("Payload byte on slots %b with nothing left to expect", $sampled(packet_data_valid));
        error_count++;
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        |packet_data_valid |-> packet_data == payload_expect[payload_read])
    else begin
        $display("FAIL %0t packet_data expected %h got %h", $time,
                 $sampled(payload_expect[payload_read]), $sampled(packet_data));
        error_count++;
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        |packet_data_valid |-> packet_data_valid == payload_slot_expect[payload_read])
    else begin
        $display("FAIL %0t packet_data_valid expected %b got %b", $time,
                 $sampled(payload_slot_expect[payload_read]), $sampled(packet_data_valid));
        error_count++;
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        fcs_pipe[1] |-> good_packet == verdict_good)
    else begin
        $display("FAIL %0t good_packet expected %b got %b", $time,
                 $sampled(verdict_good), $sampled(good_packet));
        error_count++;
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        fcs_pipe[1] |-> bad_packet == verdict_bad)
    else begin
        $display("FAIL %0t bad_packet expected %b got %b", $time,
                 $sampled(verdict_bad), $sampled(bad_packet));
        error_count++;
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        abort_pipe |-> bad_packet == abort_bad && good_packet == '0)
    else begin
        $display("FAIL %0t bad_packet expected %b got %b", $time,
                 $sampled(abort_bad), $sampled(bad_packet));
        error_count++;
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        (|good_packet) || (|bad_packet) |-> fcs_pipe[1] || abort_pipe)
    else begin
        $display("Verdict pulse at %0t with no frame end or abort behind it", $time);
        error_count++;
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        fcs_pipe[1] && (|verdict_good) |-> header_fields == header_check)
    else begin
        $display("FAIL %0t header_fields expected %h got %h", $time,
                 $sampled(header_check), $sampled(header_fields));
        error_count++;
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        abort_marker && data_enable |-> !data_ready)
    else begin
        $display("Mid-frame start byte at %0t was taken instead of aborting the frame", $time);
        error_count++;
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        drain_done |-> payload_read == payload_write)
    else begin
        $display("Payload bytes missing at the end: %0d expected, %0d received",
                 $sampled(payload_write), $sampled(payload_read));
        error_count++;
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    task automatic finish_test(input string name);
        idle_cycles(3);
        test_number++;
        $display("Test %0d %s: %0d errors", test_number, name, error_count - errors_before);
        errors_before = error_count;
    endtask

    initial begin
        void'($urandom(46));
        reset_n             = 1'b0;
        frame_byte          = '0;
        data_enable         = 1'b0;
        receive_slot_enable = '0;
        last_fcs_marker     = 1'b0;
        abort_marker        = 1'b0;
        drain_done          = 1'b0;
        good_expect         = '0;
        bad_expect          = '0;
        abort_bad           = '0;
        header_expect       = '0;
        payload_write       = '0;
        repeat (4) @(posedge clock);
        #1;
        reset_n = 1'b1;

        receive_slot_enable = 2'b11;
        build_frame(40, ETHER_TYPE_IPV4, IP_PROTOCOL_UDP, 16'h4000);
        send_frame(1'b1, 1'b1, WHOLE_FRAME);
        finish_test("valid frame on slot 1");

        build_frame(5, ETHER_TYPE_IPV4, IP_PROTOCOL_UDP, 16'h4000);
        send_frame(1'b1, 1'b1, WHOLE_FRAME);
        finish_test("short payload with pad");

        build_frame(20, ETHER_TYPE_IPV4, IP_PROTOCOL_UDP, 16'h4000);
        send_frame(1'b1, 1'b0, WHOLE_FRAME);
        finish_test("corrupted FCS");

        // IPv6 EtherType, TCP, more-fragments
        build_frame(12, 16'h86DD, IP_PROTOCOL_UDP, 16'h4000);
        send_frame(1'b0, 1'b1, WHOLE_FRAME);
        idle_cycles(2);
        build_frame(12, ETHER_TYPE_IPV4, 8'd6, 16'h4000);
        send_frame(1'b0, 1'b1, WHOLE_FRAME);
        idle_cycles(2);
        build_frame(12, ETHER_TYPE_IPV4, IP_PROTOCOL_UDP, 16'h2000);
        send_frame(1'b0, 1'b1, WHOLE_FRAME);
        finish_test("filtered frames");

        build_frame(30, ETHER_TYPE_IPV4, IP_PROTOCOL_UDP, 16'h4000);
        send_frame(1'b1, 1'b1, 20);
        idle_cycles(1);
        build_frame(24, ETHER_TYPE_IPV4, IP_PROTOCOL_UDP, 16'h4000);
        present_abort_start(frame_bytes[0]);
        send_frame(1'b1, 1'b1, WHOLE_FRAME);
        finish_test("mid-frame abort");

        receive_slot_enable = 2'b00;
        build_frame(16, ETHER_TYPE_IPV4, IP_PROTOCOL_UDP, 16'h4000);
        send_frame(1'b1, 1'b1, WHOLE_FRAME);
        idle_cycles(2);
        receive_slot_enable = 2'b01;
        build_frame(16, ETHER_TYPE_IPV4, IP_PROTOCOL_UDP, 16'h4000);
        send_frame(1'b1, 1'b1, WHOLE_FRAME);
        finish_test("slot enable selection");

        drain_done = 1'b1;
        @(posedge clock);
        #1;
        drain_done = 1'b0;
        $display("Tests %0d, payload bytes %0d, verdict pulses %0d, errors %0d",
                 test_number, payload_read, verdict_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: rtl/udp_frame_receiver.sv
module udp_frame_receiver
    import udp_rx_pkg::*;
#(
    parameter int RECEIVE_SLOTS = 2
)(
    input  logic                     clock,
    input  logic                     reset_n,
    input  frame_byte_t              frame_byte,
    input  logic                     data_enable,
    input  logic [RECEIVE_SLOTS-1:0] receive_slot_enable,
    output logic                     data_ready,
    output logic [7:0]               packet_data,
    output logic [RECEIVE_SLOTS-1:0] packet_data_valid,
    output logic [RECEIVE_SLOTS-1:0] good_packet,
    output logic [RECEIVE_SLOTS-1:0] bad_packet,
    output header_fields_t           header_fields
);

    localparam int SLOT_WIDTH = slot_index_width(RECEIVE_SLOTS);

    crc_feed_t             crc_feed;
    fcs_feed_t             fcs_feed;
    logic [SLOT_WIDTH-1:0] slot;
    logic [31:0]           crc_value;

    frame_sequencer #(
        .RECEIVE_SLOTS(RECEIVE_SLOTS)
    ) sequencer (
        .clock               (clock),
        .reset_n             (reset_n),
        .frame_byte          (frame_byte),
        .data_enable         (data_enable),
        .receive_slot_enable (receive_slot_enable),
        .data_ready          (data_ready),
        .packet_data         (packet_data),
        .packet_data_valid   (packet_data_valid),
        .crc_feed            (crc_feed),
        .fcs_feed            (fcs_feed),
        .slot                (slot),
        .header_fields       (header_fields)
    );

    crc32_engine crc (
        .clock     (clock),
        .reset_n   (reset_n),
        .crc_feed  (crc_feed),
        .crc_value (crc_value)
    );

    frame_verdict #(
        .RECEIVE_SLOTS(RECEIVE_SLOTS)
    ) verdict_stage (
        .clock       (clock),
        .reset_n     (reset_n),
        .fcs_feed    (fcs_feed),
        .slot        (slot),
        .crc_value   (crc_value),
        .good_packet (good_packet),
        .bad_packet  (bad_packet)
    );

endmodule

// File: rtl/frame_sequencer.sv
module frame_sequencer
    import udp_rx_pkg::*;
#(
    parameter int RECEIVE_SLOTS = 2,
    localparam int SLOT_WIDTH = slot_index_width(RECEIVE_SLOTS)
)(
    input  logic                     clock,
    input  logic                     reset_n,
    input  frame_byte_t              frame_byte,
    input  logic                     data_enable,
    input  logic [RECEIVE_SLOTS-1:0] receive_slot_enable,
    output logic                     data_ready,
    output logic [7:0]               packet_data,
    output logic [RECEIVE_SLOTS-1:0] packet_data_valid,
    output crc_feed_t                crc_feed,
    output fcs_feed_t                fcs_feed,
    output logic [SLOT_WIDTH-1:0]    slot,
    output header_fields_t           header_fields
);

    parser_state_t            state;
    parser_state_t            state_next;
    logic [15:0]              field_count;
    logic [15:0]              field_count_next;
    logic [SLOT_WIDTH-1:0]    slot_next;
    logic [SLOT_WIDTH-1:0]    start_slot;
    logic [RECEIVE_SLOTS-1:0] payload_valid_next;
    logic [7:0]               held_byte;
    logic [15:0]              field_value;
    logic [15:0]              total_length;
    logic [15:0]              payload_bytes;
    logic [15:0]              pad_bytes;
    logic                     busy;
    logic                     abort;
    logic                     take;
    logic                     field_end;

    function automatic logic [15:0] field_length(
        input parser_state_t s,
        input logic [15:0]   payload,
        input logic [15:0]   padding
    );
        case (s)
            mac_destination, mac_source: return 16'd6;
            ipv4_version, ipv4_services: return 16'd1;
            ipv4_time_to_live, ipv4_protocol: return 16'd1;
            ipv4_source_address, ipv4_destination_address: return 16'd4;
            frame_check_sequence: return 16'd4;
            udp_payload: return payload;
            pad: return padding;
            default: return 16'd2;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Handshake
    //////////////////////////////////////////////////

    assign busy       = !(state inside {idle, drop, verdict});
    assign abort      = busy && data_enable && frame_byte.start;
    assign data_ready = (state != verdict) && !abort;
    assign take       = data_enable && data_ready;
    assign field_end  = take && (field_count == 16'd0);

    // Two-byte fields arrive high byte first
    assign field_value   = {held_byte, frame_byte.data};
    assign payload_bytes = total_length - 16'(HEADER_OVERHEAD_BYTES);
    assign pad_bytes     = (payload_bytes < 16'(MIN_PAYLOAD_BYTES)) ?
                           16'(MIN_PAYLOAD_BYTES) - payload_bytes : 16'd0;

    // Highest enabled slot wins
    always_comb begin
        start_slot = '0;
        for (int i = 0; i < RECEIVE_SLOTS; i++) begin
            if (receive_slot_enable[i]) begin
                start_slot = SLOT_WIDTH'(i);
            end
        end
    end

    //////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////

    always_comb begin
        state_next         = state;
        field_count_next   = field_count;
        slot_next          = slot;
        payload_valid_next = '0;
        crc_feed           = '{data: frame_byte.data, valid: 1'b0, first: 1'b0};
        fcs_feed           = '{data: frame_byte.data, valid: 1'b0, last: 1'b0, abort: 1'b0};

        case (state)
            idle, drop: begin
                if (take && frame_byte.start) begin
                    if (|receive_slot_enable) begin
                        // Start byte is the first of six destination bytes
                        state_next       = mac_destination;
                        field_count_next = 16'd4;
                        slot_next        = start_slot;
                        crc_feed.valid   = 1'b1;
                        crc_feed.first   = 1'b1;
                    end else begin
                        state_next = drop;
                    end
                end
            end
            verdict: begin
                state_next = idle;
            end
            default: begin
                if (take) begin
                    crc_feed.valid = (state != frame_check_sequence);
                    fcs_feed.valid = (state == frame_check_sequence);
                    fcs_feed.last  = (state == frame_check_sequence) && field_end;
                    if (state == udp_payload) begin
                        payload_valid_next[slot] = 1'b1;
                    end

                    if (!field_end) begin
                        field_count_next = field_count - 16'd1;
                    end else begin
                        state_next = state.next();
                        case (state)
                            ether_type: begin
                                if (field_value != ETHER_TYPE_IPV4) begin
                                    state_next = drop;
                                end
                            end
                            ipv4_flags: begin
                                // More-fragments bit and fragment offset
                                if (field_value[13:0] != 14'd0) begin
                                    state_next = drop;
                                end
                            end
                            ipv4_protocol: begin
                                if (frame_byte.data != IP_PROTOCOL_UDP) begin
                                    state_next = drop;
                                end
                            end
                            udp_checksum: begin
                                if (payload_bytes == 16'd0) begin
                                    state_next = pad;
                                end
                            end
                            udp_payload: begin
                                if (pad_bytes == 16'd0) begin
                                    state_next = frame_check_sequence;
                                end
                            end
                            default: ;
                        endcase
                        field_count_next = field_length(state_next, payload_bytes,
                                                        pad_bytes) - 16'd1;
                    end
                end
            end
        endcase

        // Start byte is left on the bus and picked up from idle
        if (abort) begin
            fcs_feed.abort = 1'b1;
            state_next     = idle;
        end
    end

    //////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state             <= idle;
            field_count       <= '0;
            slot              <= '0;
            packet_data_valid <= '0;
            header_fields     <= '0;
        end else begin
            state             <= state_next;
            field_count       <= field_count_next;
            slot              <= slot_next;
            packet_data_valid <= payload_valid_next;
            if (field_end) begin
                case (state)
                    ipv4_identification:  header_fields.ipv4_identification <= field_value;
                    ipv4_flags:           header_fields.ipv4_flags          <= field_value;
                    udp_destination_port: header_fields.udp_destination     <= field_value;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            held_byte <= frame_byte.data;
        end
        if (take && state == udp_payload) begin
            packet_data <= frame_byte.data;
        end
        if (field_end && state == ipv4_total_length) begin
            total_length <= field_value;
        end
    end

    // Source is stalled for the verdict cycle after the last FCS byte
    assert property (@(posedge clock) disable iff (!reset_n)
        fcs_feed.last |=> state == verdict && !data_ready);

    assert property (@(posedge clock) disable iff (!reset_n)
        |packet_data_valid |-> $onehot(packet_data_valid));

endmodule

// File: rtl/frame_verdict.sv
module frame_verdict
    import udp_rx_pkg::*;
#(
    parameter int RECEIVE_SLOTS = 2,
    localparam int SLOT_WIDTH = slot_index_width(RECEIVE_SLOTS)
)(
    input  logic                     clock,
    input  logic                     reset_n,
    input  fcs_feed_t                fcs_feed,
    input  logic [SLOT_WIDTH-1:0]    slot,
    input  logic [31:0]              crc_value,
    output logic [RECEIVE_SLOTS-1:0] good_packet,
    output logic [RECEIVE_SLOTS-1:0] bad_packet
);

    logic [1:0]               fcs_count;
    logic [31:0]              received_fcs;
    logic [31:0]              frozen_crc;
    logic                     compare_pending;
    logic [RECEIVE_SLOTS-1:0] good_next;
    logic [RECEIVE_SLOTS-1:0] bad_next;

    //////////////////////////////////////////////////
    // FCS capture
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            fcs_count       <= '0;
            compare_pending <= 1'b0;
        end else begin
            compare_pending <= fcs_feed.valid && fcs_feed.last;
            if (fcs_feed.abort) begin
                fcs_count <= '0;
            end else if (fcs_feed.valid) begin
                fcs_count <= fcs_count + 2'd1;
            end
        end
    end

    // FCS goes out least significant byte first
    always_ff @(posedge clock) begin
        if (fcs_feed.valid) begin
            received_fcs <= {fcs_feed.data, received_fcs[31:8]};
        end
        if (fcs_feed.valid && fcs_count == 2'd0) begin
            frozen_crc <= crc_value;
        end
    end

    //////////////////////////////////////////////////
    // Verdict pulses
    //////////////////////////////////////////////////

    always_comb begin
        good_next = '0;
        bad_next  = '0;
        if (compare_pending) begin
            if (received_fcs == frozen_crc) begin
                good_next[slot] = 1'b1;
            end else begin
                bad_next[slot] = 1'b1;
            end
        end
        if (fcs_feed.abort) begin
            bad_next[slot] = 1'b1;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            good_packet <= '0;
            bad_packet  <= '0;
        end else begin
            good_packet <= good_next;
            bad_packet  <= bad_next;
        end
    end

    // Good and bad never pulse together
    assert property (@(posedge clock) disable iff (!reset_n)
        |good_packet |-> !(|bad_packet));

endmodule

// File: rtl/crc32_engine.sv
module crc32_engine
    import udp_rx_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    input  crc_feed_t   crc_feed,
    output logic [31:0] crc_value
);

    logic [31:0] crc_state;
    logic [31:0] crc_seed;

    // One byte, LSB first, reflected polynomial
    function automatic logic [31:0] crc32_byte(
        input logic [31:0] crc,
        input logic [7:0]  data
    );
        logic [31:0] c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC32_POLYNOMIAL;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // First byte of a frame starts from all ones again
    assign crc_seed = crc_feed.first ? 32'hFFFF_FFFF : crc_state;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            crc_state <= 32'hFFFF_FFFF;
        end else if (crc_feed.valid) begin
            crc_state <= crc32_byte(crc_seed, crc_feed.data);
        end
    end

    assign crc_value = ~crc_state;

endmodule

// File: rtl/udp_rx_pkg.sv
package udp_rx_pkg;

    //////////////////////////////////////////////////
    // Protocol constants
    //////////////////////////////////////////////////

    localparam logic [15:0] ETHER_TYPE_IPV4       = 16'h0800;
    localparam logic [7:0]  IP_PROTOCOL_UDP       = 8'd17;

    // IPv4 header plus UDP header, no options
    localparam int          HEADER_OVERHEAD_BYTES = 28;

    // Payload size at which the frame reaches 64 bytes without pad
    localparam int          MIN_PAYLOAD_BYTES     = 18;

    // Bit-reversed 0x04C11DB7
    localparam logic [31:0] CRC32_POLYNOMIAL      = 32'hEDB88320;

    function automatic int slot_index_width(input int slots);
        return (slots > 1) ? $clog2(slots) : 1;
    endfunction

    //////////////////////////////////////////////////
    // Stream and feed types
    //////////////////////////////////////////////////

    // Start sits on top, as bit 8 of the old 9-bit bus
    typedef struct packed {
        logic       start;
        logic [7:0] data;
    } frame_byte_t;

    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       first;
    } crc_feed_t;

    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       last;
        logic       abort;
    } fcs_feed_t;

    typedef struct packed {
        logic [15:0] udp_destination;
        logic [15:0] ipv4_flags;
        logic [15:0] ipv4_identification;
    } header_fields_t;

    // Header states follow wire order, the sequencer steps with next()
    typedef enum logic [4:0] {
        idle,
        mac_destination,
        mac_source,
        ether_type,
        ipv4_version,
        ipv4_services,
        ipv4_total_length,
        ipv4_identification,
        ipv4_flags,
        ipv4_time_to_live,
        ipv4_protocol,
        ipv4_header_checksum,
        ipv4_source_address,
        ipv4_destination_address,
        udp_source_port,
        udp_destination_port,
        udp_length,
        udp_checksum,
        udp_payload,
        pad,
        frame_check_sequence,
        verdict,
        drop
    } parser_state_t;

endpackage
